// ==== design/accel_core_defs.svh ====
////////////////////////////////////////////////////////////
// accelerator build parameters
// operand width, FIFO depths, APB register offsets
////////////////////////////////////////////////////////////
`ifndef ACCEL_CORE_DEFS_SVH
`define ACCEL_CORE_DEFS_SVH

// signed operand width
`define ACCEL_WIDTH 8

// queue depths, result queue must hold ACCEL_WIDTH+1 or more
`define ACCEL_OP_DEPTH 8
`define ACCEL_RES_DEPTH 16

// register map
`define ACCEL_ADDR_OPERANDS 12'h000
`define ACCEL_ADDR_STATUS 12'h004
`define ACCEL_ADDR_RESULT 12'h008

`endif

// ==== design/accel_core_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types of the multiply accelerator
// operand/product vectors, APB vectors, operand pair, APB request
////////////////////////////////////////////////////////////
`default_nettype none

`include "accel_core_defs.svh"

package accel_core_pkg;

    typedef logic signed [`ACCEL_WIDTH-1:0] operand_t;
    typedef logic signed [2*`ACCEL_WIDTH-1:0] product_t;
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // qu in the upper byte, mu in the lower byte
    typedef struct packed {
        operand_t qu;
        operand_t mu;
    } operand_pair_t;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

endpackage

`default_nettype wire

// ==== design/accel_core_fifo.sv ====
////////////////////////////////////////////////////////////
// synchronous fall-through FIFO with fill count
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module accel_core_fifo #(
    parameter int DATA_W = 16,
    parameter int DEPTH = 8,
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
    localparam int CNT_W = $clog2(DEPTH+1)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  logic [DATA_W-1:0] push_data,
    input  logic              pop,
    output logic [DATA_W-1:0] pop_data,
    output logic [CNT_W-1:0]  count,
    output logic              full,
    output logic              empty
);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              do_push;
    logic              do_pop;

    // illegal requests are dropped
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    assign full = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // head entry visible while not empty
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/accel_core_apb_regs.sv ====
////////////////////////////////////////////////////////////
// APB slave register block
// operand push, result pop, status word, error response
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "accel_core_defs.svh"

module accel_core_apb_regs
    import accel_core_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  apb_req_t                               apb_req,
    output apb_data_t                              prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    output logic                                   op_push,
    output operand_pair_t                          op_data,
    input  logic                                   op_full,
    input  logic [$clog2(`ACCEL_OP_DEPTH+1)-1:0]   op_count,
    output logic                                   res_pop,
    input  product_t                               res_data,
    input  logic                                   res_empty,
    input  logic [$clog2(`ACCEL_RES_DEPTH+1)-1:0]  res_count
);

    localparam int OP_CNT_W = $clog2(`ACCEL_OP_DEPTH+1);
    localparam int RES_CNT_W = $clog2(`ACCEL_RES_DEPTH+1);
    localparam int PROD_W = $bits(product_t);

    logic      setup;
    logic      access;
    apb_data_t status_word;
    apb_data_t rd_data_d;
    logic      err_d;

    assign setup = apb_req.psel && !apb_req.penable;
    assign access = apb_req.psel && apb_req.penable;

    // no wait states
    assign pready = 1'b1;

    assign op_data = operand_pair_t'(apb_req.pwdata[15:0]);

    always_comb begin
        status_word = '0;
        status_word[OP_CNT_W-1:0] = op_count;
        status_word[8 +: RES_CNT_W] = res_count;
        status_word[16] = op_full;
        status_word[17] = res_empty;
    end

    // response decided during setup, presented in the access cycle
    always_comb begin
        rd_data_d = '0;
        err_d = 1'b0;
        case (apb_req.paddr)
            `ACCEL_ADDR_OPERANDS: begin
                // write-only, a full queue refuses the pair
                err_d = !apb_req.pwrite || op_full;
            end
            `ACCEL_ADDR_STATUS: begin
                err_d = apb_req.pwrite;
                rd_data_d = status_word;
            end
            `ACCEL_ADDR_RESULT: begin
                err_d = apb_req.pwrite || res_empty;
                if (!apb_req.pwrite && !res_empty) begin
                    rd_data_d = {{(32-PROD_W){res_data[PROD_W-1]}}, res_data};
                end
            end
            default: begin
                err_d = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prdata <= '0;
            pslverr <= 1'b0;
        end else if (setup) begin
            prdata <= err_d ? '0 : rd_data_d;
            pslverr <= err_d;
        end else begin
            prdata <= '0;
            pslverr <= 1'b0;
        end
    end

    // one strobe per access, on the access edge
    assign op_push = access && apb_req.pwrite && !pslverr &&
                     (apb_req.paddr == `ACCEL_ADDR_OPERANDS);
    assign res_pop = access && !apb_req.pwrite && !pslverr &&
                     (apb_req.paddr == `ACCEL_ADDR_RESULT);

endmodule

`default_nettype wire

// ==== design/accel_core_booth_pipeline.sv ====
////////////////////////////////////////////////////////////
// credit-based issue stage
// radix-2 Booth multiplier, one stage per multiplier bit
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "accel_core_defs.svh"

module accel_core_booth_pipeline
    import accel_core_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   op_empty,
    input  operand_pair_t                          op_data,
    output logic                                   op_pop,
    input  logic [$clog2(`ACCEL_RES_DEPTH+1)-1:0]  res_count,
    output logic                                   out_valid,
    output product_t                               product
);

    localparam int W = `ACCEL_WIDTH;
    // accumulator carries one extra bit so -2^(W-1) as multiplicand does not overflow
    localparam int REC_W = 2*W + 2;
    localparam int RES_CNT_W = $clog2(`ACCEL_RES_DEPTH+1);
    localparam int FLIGHT_W = $clog2(W+2);

    typedef struct packed {
        logic [REC_W-1:0] aqq;
        operand_t         mu;
        logic             valid;
    } stage_t;

    stage_t               stage_q [W+1];
    logic [FLIGHT_W-1:0]  in_flight;
    logic [RES_CNT_W:0]   credit_used;

    function automatic logic [REC_W-1:0] booth_step(input logic [REC_W-1:0] rec,
                                                    input operand_t mu);
        logic signed [W:0] upper;
        logic signed [W:0] mu_ext;
        mu_ext = {mu[W-1], mu};
        upper = rec[REC_W-1:W+1];
        case (rec[1:0])
            2'b01: upper = upper + mu_ext;
            2'b10: upper = upper - mu_ext;
            default: upper = upper;
        endcase
        booth_step = $signed({upper, rec[W:0]}) >>> 1;
    endfunction

    // issue only when every item in flight has a result slot
    assign credit_used = (RES_CNT_W+1)'(in_flight) + (RES_CNT_W+1)'(res_count);
    assign op_pop = !op_empty && (credit_used < (RES_CNT_W+1)'(`ACCEL_RES_DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            case ({op_pop, out_valid})
                2'b10: in_flight <= in_flight + 1'b1;
                2'b01: in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i <= W; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            // capture stage, guard bit cleared
            stage_q[0].aqq <= {{(W+1){1'b0}}, op_data.qu, 1'b0};
            stage_q[0].mu <= op_data.mu;
            stage_q[0].valid <= op_pop;
            for (int i = 0; i < W; i++) begin
                stage_q[i+1].aqq <= booth_step(stage_q[i].aqq, stage_q[i].mu);
                stage_q[i+1].mu <= stage_q[i].mu;
                stage_q[i+1].valid <= stage_q[i].valid;
            end
        end
    end

    assign out_valid = stage_q[W].valid;
    // drop guard bit and the extra sign bit
    assign product = stage_q[W].aqq[2*W:1];

endmodule

`default_nettype wire

// ==== design/accel_core_top.sv ====
////////////////////////////////////////////////////////////
// multiply accelerator top level
// APB registers, operand and result FIFOs, Booth pipeline
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "accel_core_defs.svh"

module accel_core_top
    import accel_core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  apb_req_t  apb_req,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr
);

    // host side of the operand queue
    logic                                  op_push;
    operand_pair_t                         op_wdata;
    logic                                  op_full;
    logic [$clog2(`ACCEL_OP_DEPTH+1)-1:0]  op_count;
    // pipeline side of the operand queue
    logic                                  op_pop;
    operand_pair_t                         op_rdata;
    logic                                  op_empty;
    // result queue
    logic                                  res_pop;
    product_t                              res_rdata;
    logic                                  res_full;
    logic                                  res_empty;
    logic [$clog2(`ACCEL_RES_DEPTH+1)-1:0] res_count;
    logic                                  out_valid;
    product_t                              product;

    accel_core_apb_regs apb_regs_i (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .op_push   (op_push),
        .op_data   (op_wdata),
        .op_full   (op_full),
        .op_count  (op_count),
        .res_pop   (res_pop),
        .res_data  (res_rdata),
        .res_empty (res_empty),
        .res_count (res_count)
    );

    accel_core_fifo #(
        .DATA_W ($bits(operand_pair_t)),
        .DEPTH  (`ACCEL_OP_DEPTH)
    ) op_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (op_push),
        .push_data (op_wdata),
        .pop       (op_pop),
        .pop_data  (op_rdata),
        .count     (op_count),
        .full      (op_full),
        .empty     (op_empty)
    );

    accel_core_booth_pipeline booth_i (
        .clk       (clk),
        .rst       (rst),
        .op_empty  (op_empty),
        .op_data   (op_rdata),
        .op_pop    (op_pop),
        .res_count (res_count),
        .out_valid (out_valid),
        .product   (product)
    );

    // credit rule keeps res_full low whenever out_valid is high
    accel_core_fifo #(
        .DATA_W ($bits(product_t)),
        .DEPTH  (`ACCEL_RES_DEPTH)
    ) res_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (out_valid),
        .push_data (product),
        .pop       (res_pop),
        .pop_data  (res_rdata),
        .count     (res_count),
        .full      (res_full),
        .empty     (res_empty)
    );

endmodule

`default_nettype wire

// ==== testbench/accel_core_properties.sv ====
////////////////////////////////////////////////////////////
// concurrent checks bound into the accelerator top
// APB sequencing, FIFO overflow and underflow, pready
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module accel_core_properties
    import accel_core_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input apb_req_t apb_req,
    input logic     pready,
    input logic     op_push,
    input logic     op_full,
    input logic     out_valid,
    input logic     res_full,
    input logic     res_pop,
    input logic     res_empty
);

    // access phase only after a setup cycle
    apb_penable_after_psel: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel && $past(apb_req.psel))
        else $error("penable without a preceding psel");

    op_no_overflow: assert property (@(posedge clk) disable iff (rst) !(op_push && op_full))
        else $error("push into a full operand FIFO");

    // credit rule must keep a slot free for every product
    res_no_overflow: assert property (@(posedge clk) disable iff (rst) !(out_valid && res_full))
        else $error("product pushed into a full result FIFO");

    res_no_underflow: assert property (@(posedge clk) disable iff (rst) !(res_pop && res_empty))
        else $error("pop from an empty result FIFO");

    ready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready dropped");

endmodule

`default_nettype wire

// ==== testbench/accel_core_tb.sv ====
////////////////////////////////////////////////////////////
// testbench for the multiply accelerator
// clock and reset, APB tasks, pattern-file stimulus, checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "accel_core_defs.svh"

module accel_core_tb
    import accel_core_pkg::*;
();

    localparam int NUM_PATTERNS = 14;
    localparam int BURST = `ACCEL_RES_DEPTH + `ACCEL_OP_DEPTH;
    localparam int CYCLE_LIMIT = 40 * NUM_PATTERNS + 200;

    logic        clk;
    logic        rst;
    apb_req_t    apb_req;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] patterns [NUM_PATTERNS];
    product_t    expected_q [$];
    logic [31:0] rng;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    accel_core_top accel_core_top_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    bind accel_core_top accel_core_properties props_i (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .pready    (pready),
        .op_push   (op_push),
        .op_full   (op_full),
        .out_valid (out_valid),
        .res_full  (res_full),
        .res_pop   (res_pop),
        .res_empty (res_empty)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT never delivered all results", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string what, input apb_data_t got, input apb_data_t exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // setup cycle, access cycle, then idle
    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        @(negedge clk);
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = wr;
        apb_req.paddr = addr;
        apb_req.pwdata = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        // response was registered on the setup edge
        rdata = prdata;
        err = pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic write_pair(input operand_t mu, input operand_t qu, output logic err);
        apb_data_t unused;
        apb_access(1'b1, `ACCEL_ADDR_OPERANDS, {16'h0000, qu, mu}, unused, err);
    endtask

    task automatic read_status(output apb_data_t status);
        logic err;
        apb_access(1'b0, `ACCEL_ADDR_STATUS, '0, status, err);
        check_value("status read error", apb_data_t'(err), 32'd0);
    endtask

    // one RESULT read against the oldest expected product
    task automatic read_result();
        apb_data_t data;
        logic      err;
        product_t  exp;
        apb_access(1'b0, `ACCEL_ADDR_RESULT, '0, data, err);
        if (err) begin
            check_value("empty result read data", data, 32'd0);
        end else if (expected_q.size() == 0) begin
            $display("a result appeared that was never written: %h", data);
            errors++;
        end else begin
            exp = expected_q.pop_front();
            check_value("result", data, apb_data_t'(exp));
        end
    endtask

    task automatic check_illegal(input logic wr, input apb_addr_t addr, input string what);
        apb_data_t data;
        logic      err;
        apb_access(wr, addr, 32'hffff_ffff, data, err);
        check_value(what, apb_data_t'(err), 32'd1);
        check_value({what, " data"}, data, 32'd0);
    endtask

    initial begin
        apb_data_t status;
        apb_data_t data;
        logic      err;
        operand_t  mu;
        operand_t  qu;
        rst = 1'b1;
        apb_req = '0;
        rng = 32'hd64f;
        $readmemh("testbench/accel_core_patterns.txt", patterns);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle state after reset
        read_status(status);
        check_value("status after reset", status, 32'h0002_0000);
        apb_access(1'b0, `ACCEL_ADDR_RESULT, '0, data, err);
        check_value("empty result error", apb_data_t'(err), 32'd1);
        check_value("empty result data", data, 32'd0);

        // pattern stream with random gaps and early reads
        for (int i = 0; i < NUM_PATTERNS; i++) begin
            if ($isunknown(patterns[i])) begin
                $display("pattern line %0d is missing or unreadable", i);
                errors++;
            end
            write_pair(patterns[i][31:24], patterns[i][23:16], err);
            check_value("pattern write error", apb_data_t'(err), 32'd0);
            expected_q.push_back(product_t'(patterns[i][15:0]));
            rng = lcg_next(rng);
            repeat (rng[17:16]) @(negedge clk);
            if (rng[20]) begin
                read_result();
            end
        end
        while (expected_q.size() != 0) begin
            read_result();
        end

        // fill both queues until the next pair is refused
        for (int i = 0; i < BURST; i++) begin
            rng = lcg_next(rng);
            mu = rng[23:16];
            qu = rng[31:24];
            write_pair(mu, qu, err);
            check_value("burst write error", apb_data_t'(err), 32'd0);
            expected_q.push_back(product_t'(mu) * product_t'(qu));
        end
        write_pair(8'h5a, 8'h5a, err);
        check_value("overflow write error", apb_data_t'(err), 32'd1);
        status = '0;
        while (status[12:8] != 5'(`ACCEL_RES_DEPTH)) begin
            read_status(status);
        end
        check_value("status when full", status, 32'h0001_1008);

        // illegal accesses leave the queues alone
        check_illegal(1'b1, `ACCEL_ADDR_STATUS, "status write");
        check_illegal(1'b1, `ACCEL_ADDR_RESULT, "result write");
        check_illegal(1'b0, `ACCEL_ADDR_OPERANDS, "operand read");
        check_illegal(1'b0, 12'h00c, "unmapped read");
        check_illegal(1'b1, 12'h010, "unmapped write");
        read_status(status);
        check_value("status after illegal accesses", status, 32'h0001_1008);

        // drain without the refused pair showing up
        while (expected_q.size() != 0) begin
            read_result();
        end
        read_result();
        read_status(status);
        check_value("status after drain", status, 32'h0002_0000);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/accel_core_patterns.txt ====
// one hex word per line: mu [31:24], qu [23:16], expected signed product [15:0]
// sign corner cases first
80804000
807fc080
005a0000
ffff0001
7f7f3f01
0305000f
fd05fff1
7f80c080
123403a8
c81bfa18
0180ff80
9c64d8f0
55aae372
ff01ffff

// ==== project.f ====
+incdir+design
design/accel_core_pkg.sv
design/accel_core_fifo.sv
design/accel_core_apb_regs.sv
design/accel_core_booth_pipeline.sv
design/accel_core_top.sv
testbench/accel_core_properties.sv
testbench/accel_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the accelerator testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module accel_core_tb -o accel_core_sim

# a stopped simulation still has its output searched
output="$(./obj_dir/accel_core_sim)" || true
echo "$output"

if grep -qx "RESULT: PASS" <<< "$output"; then
    exit 0
fi
exit 1
